/* rtl/led_pkg.sv */
package led_pkg;

   // Digits held by the counter and shown over both banks.
   parameter int NUM_DIGITS = 8;

   // Positions per display bank, one anode each.
   parameter int DIGITS_PER_BANK = 4;

   // Largest value of a decade stage.
   parameter logic [3:0] DIGIT_MAX = 4'd9;

   // One BCD digit.
   typedef logic [3:0] digit_t;

   // Segments a to g in bits 0 to 6, decimal point in bit 7, active low.
   typedef logic [7:0] seg_t;

   // Anode enables for one bank, active low.
   typedef logic [DIGITS_PER_BANK-1:0] anode_t;

   // Segment word with every segment dark.
   parameter seg_t SEG_BLANK = 8'hFF;

   // Anode word with no digit selected.
   parameter anode_t ANODE_OFF = '1;

   // Anode pattern that lights one position of a bank.
   function automatic anode_t anode_for_slot(input logic [1:0] slot);
      anode_t pattern;
      pattern = ANODE_OFF;
      pattern[slot] = 1'b0;
      return pattern;
   endfunction

endpackage

/* rtl/bcd_digit.sv */
`timescale 1ns/1ps

module bcd_digit (
   input  logic            clk,
   input  logic            reset_n,
   input  logic            stp,
   input  logic            count_en,
   output led_pkg::digit_t value,
   output logic            carry
);

   import led_pkg::*;

   digit_t value_next;
   logic   at_max;
   logic   advance;

   assign at_max  = (value == DIGIT_MAX);
   assign advance = count_en && !stp;

   // Wraps from nine back to zero.
   always_comb begin
      value_next = value;
      if (advance) begin
         if (at_max) begin
            value_next = '0;
         end else begin
            value_next = value + 4'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         value <= '0;
      end else begin
         value <= value_next;
      end
   end

   // Next stage steps on the same edge as this one.
   assign carry = count_en && at_max;

endmodule

/* rtl/bcd_counter.sv */
`timescale 1ns/1ps

module bcd_counter #(
   parameter int NUM_DIGITS = 8
) (
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic                             stp,
   output led_pkg::digit_t [NUM_DIGITS-1:0] digits
);

   // Enable into each stage, plus the carry out of the last one.
   logic [NUM_DIGITS:0] stage_en;

   // Least significant stage counts every enabled edge.
   assign stage_en[0] = 1'b1;

   genvar i;
   generate
      for (i = 0; i < NUM_DIGITS; i++) begin : g_stage
         bcd_digit u_digit (
            .clk      (clk),
            .reset_n  (reset_n),
            .stp      (stp),
            .count_en (stage_en[i]),
            .value    (digits[i]),
            .carry    (stage_en[i+1])
         );
      end
   endgenerate

   // stage_en[NUM_DIGITS] goes nowhere, so the full count wraps to zero.

endmodule

/* rtl/seven_seg_encoder.sv */
`timescale 1ns/1ps

module seven_seg_encoder (
   input  led_pkg::digit_t digit,
   output led_pkg::seg_t   seg
);

   import led_pkg::*;

   // Segment order is dp g f e d c b a, all active low.
   always_comb begin
      case (digit)
         4'd0: begin
            seg = 8'hC0;
         end
         4'd1: begin
            seg = 8'hF9;
         end
         4'd2: begin
            seg = 8'hA4;
         end
         4'd3: begin
            seg = 8'hB0;
         end
         4'd4: begin
            seg = 8'h99;
         end
         4'd5: begin
            seg = 8'h92;
         end
         4'd6: begin
            seg = 8'h82;
         end
         4'd7: begin
            seg = 8'hF8;
         end
         4'd8: begin
            seg = 8'h80;
         end
         4'd9: begin
            seg = 8'h90;
         end
         // Codes above nine are not decimal.
         default: begin
            seg = SEG_BLANK;
         end
      endcase
   end

endmodule

/* rtl/display_scanner.sv */
`timescale 1ns/1ps

module display_scanner #(
   parameter int NUM_DIGITS = 8,
   parameter int SCAN_SHIFT = 4
) (
   input  logic                             clk,
   input  logic                             reset_n,
   input  led_pkg::digit_t [NUM_DIGITS-1:0] digits,
   output led_pkg::seg_t                    seg_x,
   output led_pkg::seg_t                    seg_y,
   output led_pkg::anode_t                  anode_x,
   output led_pkg::anode_t                  anode_y
);

   import led_pkg::*;

   localparam int CNT_W = SCAN_SHIFT + 2;

   logic [CNT_W-1:0]      scan_cnt;
   logic [1:0]            slot;
   logic [SCAN_SHIFT-1:0] phase;
   logic                  blanking;
   anode_t                slot_anode;

   digit_t                digit_x;
   digit_t                digit_y;
   seg_t                  enc_x;
   seg_t                  enc_y;

   // Free-running scan counter.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         scan_cnt <= '0;
      end else begin
         scan_cnt <= scan_cnt + CNT_W'(1);
      end
   end

   assign slot  = scan_cnt[CNT_W-1 -: 2];
   assign phase = scan_cnt[SCAN_SHIFT-1:0];

   // First cycle of every slot is dark to avoid ghosting.
   assign blanking   = (phase == '0);
   assign slot_anode = anode_for_slot(slot);

   // Bank y holds the low digits, bank x the high ones.
   assign digit_y = digits[slot];
   assign digit_x = digits[DIGITS_PER_BANK + slot];

   seven_seg_encoder u_enc_x (
      .digit (digit_x),
      .seg   (enc_x)
   );

   seven_seg_encoder u_enc_y (
      .digit (digit_y),
      .seg   (enc_y)
   );

   // Anodes for both banks.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         anode_x <= ANODE_OFF;
         anode_y <= ANODE_OFF;
      end else if (blanking) begin
         anode_x <= ANODE_OFF;
         anode_y <= ANODE_OFF;
      end else begin
         anode_x <= slot_anode;
         anode_y <= slot_anode;
      end
   end

   // Segments hold their last pattern through the dark cycle.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         seg_x <= SEG_BLANK;
         seg_y <= SEG_BLANK;
      end else if (!blanking) begin
         seg_x <= enc_x;
         seg_y <= enc_y;
      end
   end

endmodule

/* rtl/led_counter_top.sv */
`timescale 1ns/1ps

module led_counter_top #(
   parameter int NUM_DIGITS = led_pkg::NUM_DIGITS,
   parameter int SCAN_SHIFT = 4
) (
   input  logic            clk,
   input  logic            reset_n,
   input  logic            stp,
   output led_pkg::seg_t   seg_x,
   output led_pkg::seg_t   seg_y,
   output led_pkg::anode_t anode_x,
   output led_pkg::anode_t anode_y
);

   import led_pkg::*;

   // Current count, digit 0 least significant.
   digit_t [NUM_DIGITS-1:0] digits;

   // Two banks must cover every digit of the counter.
   generate
      if (NUM_DIGITS != 2 * DIGITS_PER_BANK) begin : g_bad_size
         $error("NUM_DIGITS must equal two display banks of %0d", DIGITS_PER_BANK);
      end
   endgenerate

   bcd_counter #(
      .NUM_DIGITS (NUM_DIGITS)
   ) u_counter (
      .clk     (clk),
      .reset_n (reset_n),
      .stp     (stp),
      .digits  (digits)
   );

   display_scanner #(
      .NUM_DIGITS (NUM_DIGITS),
      .SCAN_SHIFT (SCAN_SHIFT)
   ) u_scanner (
      .clk     (clk),
      .reset_n (reset_n),
      .digits  (digits),
      .seg_x   (seg_x),
      .seg_y   (seg_y),
      .anode_x (anode_x),
      .anode_y (anode_y)
   );

endmodule

/* dv/led_counter_assert.sv */
`timescale 1ns/1ps

module led_counter_assert (
   input logic            clk,
   input logic            reset_n,
   input led_pkg::seg_t   seg_x,
   input led_pkg::seg_t   seg_y,
   input led_pkg::anode_t anode_x,
   input led_pkg::anode_t anode_y
);

   import led_pkg::*;

   // At most one digit per bank is lit.
   a_anode_x_single: assert property (@(posedge clk) disable iff (!reset_n)
      (anode_x == ANODE_OFF) || $onehot(~anode_x))
      else $error("anode_x selects more than one digit: %b", anode_x);

   a_anode_y_single: assert property (@(posedge clk) disable iff (!reset_n)
      (anode_y == ANODE_OFF) || $onehot(~anode_y))
      else $error("anode_y selects more than one digit: %b", anode_y);

   // Both banks scan in step.
   a_banks_match: assert property (@(posedge clk) disable iff (!reset_n)
      anode_x == anode_y)
      else $error("anode_x %b differs from anode_y %b", anode_x, anode_y);

   // Nothing lights right after a reset cycle.
   a_reset_dark: assert property (@(posedge clk)
      !reset_n |=> (anode_x == ANODE_OFF && anode_y == ANODE_OFF &&
                    seg_x == SEG_BLANK && seg_y == SEG_BLANK))
      else $error("display not dark after reset");

endmodule

bind led_counter_top led_counter_assert u_assert (
   .clk     (clk),
   .reset_n (reset_n),
   .seg_x   (seg_x),
   .seg_y   (seg_y),
   .anode_x (anode_x),
   .anode_y (anode_y)
);

/* dv/led_counter_tb.sv */
`timescale 1ns/1ps

module led_counter_tb;

   import led_pkg::*;

   localparam int SCAN_SHIFT   = 4;
   localparam int SCAN_LEN     = 4 << SCAN_SHIFT;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int STOP_RUNS    = 6;
   localparam int MAX_RUN      = 32;
   localparam int MAX_EXTRA    = 16;
   localparam int CARRY_TARGET = 10007;
   localparam int MODULUS      = 100000000;

   // Sum of the cycle budgets of all tests.
   localparam int BUDGET = (RESET_CYCLES + 2)
                         + 2 * SCAN_LEN
                         + 3 * SCAN_LEN
                         + STOP_RUNS * (MAX_RUN + 2 * SCAN_LEN + MAX_EXTRA + 2)
                         + SCAN_LEN + 1
                         + (RESET_CYCLES + CARRY_TARGET + SCAN_LEN + 4);
   localparam int TIMEOUT_CYCLES = BUDGET + BUDGET / 10;

   logic   clk = 1'b0;
   logic   reset_n;
   logic   stp;
   seg_t   seg_x;
   seg_t   seg_y;
   anode_t anode_x;
   anode_t anode_y;

   int     model_count;
   int     model_scan;
   anode_t exp_anode;
   seg_t   exp_seg_x;
   seg_t   exp_seg_y;

   led_counter_top #(
      .NUM_DIGITS (NUM_DIGITS),
      .SCAN_SHIFT (SCAN_SHIFT)
   ) dut (
      .clk     (clk),
      .reset_n (reset_n),
      .stp     (stp),
      .seg_x   (seg_x),
      .seg_y   (seg_y),
      .anode_x (anode_x),
      .anode_y (anode_y)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Active-low segment table in dp g f e d c b a order.
   function automatic seg_t seg_pattern(input int d);
      case (d)
         0: return 8'hC0;
         1: return 8'hF9;
         2: return 8'hA4;
         3: return 8'hB0;
         4: return 8'h99;
         5: return 8'h92;
         6: return 8'h82;
         7: return 8'hF8;
         8: return 8'h80;
         9: return 8'h90;
         default: return SEG_BLANK;
      endcase
   endfunction

   function automatic int digit_of(input int value, input int pos);
      int v;
      v = value;
      for (int i = 0; i < pos; i++) begin
         v = v / 10;
      end
      return v % 10;
   endfunction

   function automatic int slot_of(input anode_t a);
      int slot;
      slot = 0;
      for (int i = 0; i < DIGITS_PER_BANK; i++) begin
         if (!a[i]) begin
            slot = i;
         end
      end
      return slot;
   endfunction

   // Reference model computes outputs from the state before each edge.
   always @(posedge clk) begin : model
      int slot;
      int phase;
      if (!reset_n) begin
         model_count = 0;
         model_scan  = 0;
         exp_anode   = ANODE_OFF;
         exp_seg_x   = SEG_BLANK;
         exp_seg_y   = SEG_BLANK;
      end else begin
         slot  = model_scan >> SCAN_SHIFT;
         phase = model_scan % (1 << SCAN_SHIFT);
         if (phase == 0) begin
            exp_anode = ANODE_OFF;
         end else begin
            exp_anode = ~(anode_t'(1) << slot);
            exp_seg_y = seg_pattern(digit_of(model_count, slot));
            exp_seg_x = seg_pattern(digit_of(model_count, slot + DIGITS_PER_BANK));
         end
         if (!stp) begin
            model_count = (model_count + 1) % MODULUS;
         end
         model_scan = (model_scan + 1) % SCAN_LEN;
      end
   end

   task automatic check_seg(input string name, input seg_t expected, input seg_t actual);
      if (actual !== expected) begin
         $display("ERR t=%0t %s expected %02h actual %02h", $time, name, expected, actual);
         $display("TB FAILED");
         $fatal(1, "segment mismatch");
      end
   endtask

   task automatic check_anode(input string name, input anode_t expected, input anode_t actual);
      if (actual !== expected) begin
         $display("ERR t=%0t %s expected %b actual %b", $time, name, expected, actual);
         $display("TB FAILED");
         $fatal(1, "anode mismatch");
      end
   endtask

   task automatic check_outputs();
      check_anode("anode_x", exp_anode, anode_x);
      check_anode("anode_y", exp_anode, anode_y);
      check_seg("seg_x", exp_seg_x, seg_x);
      check_seg("seg_y", exp_seg_y, seg_y);
   endtask

   task automatic check_dark();
      check_anode("anode_x", ANODE_OFF, anode_x);
      check_anode("anode_y", ANODE_OFF, anode_y);
      check_seg("seg_x", SEG_BLANK, seg_x);
      check_seg("seg_y", SEG_BLANK, seg_y);
   endtask

   // One clock with stp driven and outputs checked at the falling edge.
   task automatic step(input logic stop);
      @(posedge clk);
      stp <= stop;
      @(negedge clk);
      check_outputs();
   endtask

   // Expects reset_n already low before the next rising edge.
   task automatic hold_reset();
      for (int i = 1; i <= RESET_CYCLES; i++) begin
         @(posedge clk);
         if (i == RESET_CYCLES) begin
            reset_n <= 1'b1;
         end
         @(negedge clk);
         check_dark();
      end
   endtask

   task automatic reset_test();
      hold_reset();
      step(1'b0);
      check_dark();
   endtask

   task automatic scan_order_test();
      int blanks;
      blanks = 0;
      repeat (2 * SCAN_LEN) begin
         step(1'b0);
         if (anode_x == ANODE_OFF) begin
            blanks++;
         end
      end
      if (blanks != 2 * DIGITS_PER_BANK) begin
         $display("Two scans showed %0d dark cycles instead of %0d",
                  blanks, 2 * DIGITS_PER_BANK);
         $display("TB FAILED");
         $fatal(1, "wrong blanking");
      end
   endtask

   task automatic counting_test();
      repeat (3 * SCAN_LEN) begin
         step(1'b0);
      end
   endtask

   task automatic stop_test();
      int run_len;
      int freeze_len;
      int frozen;
      int slot;
      for (int r = 0; r < STOP_RUNS; r++) begin
         run_len    = 1 + ($urandom % MAX_RUN);
         freeze_len = 2 * SCAN_LEN + ($urandom % MAX_EXTRA);
         repeat (run_len) begin
            step(1'b0);
         end
         step(1'b1);
         frozen = model_count;
         // The same digits must come back in every scan while stopped.
         repeat (freeze_len) begin
            step(1'b1);
            if (exp_anode != ANODE_OFF) begin
               slot = slot_of(exp_anode);
               check_seg("seg_y", seg_pattern(digit_of(frozen, slot)), seg_y);
               check_seg("seg_x", seg_pattern(digit_of(frozen, slot + DIGITS_PER_BANK)), seg_x);
            end
         end
      end
      repeat (SCAN_LEN + 1) begin
         step(1'b0);
      end
   endtask

   task automatic carry_test();
      @(posedge clk);
      reset_n <= 1'b0;
      stp     <= 1'b0;
      hold_reset();
      while (model_count != CARRY_TARGET - 1) begin
         step(1'b0);
      end
      step(1'b1);
      repeat (SCAN_LEN + 1) begin
         step(1'b1);
         if (exp_anode != ANODE_OFF && slot_of(exp_anode) == 0) begin
            check_seg("seg_x", seg_pattern(1), seg_x);
         end
      end
      step(1'b0);
   endtask

   initial begin : watchdog
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      reset_n = 1'b0;
      stp     = 1'b0;
      void'($urandom(76));
      reset_test();
      scan_order_test();
      counting_test();
      stop_test();
      carry_test();
      $display("TB PASSED");
      $finish;
   end

endmodule

/* verilog.f */
rtl/led_pkg.sv
rtl/bcd_digit.sv
rtl/bcd_counter.sv
rtl/seven_seg_encoder.sv
rtl/display_scanner.sv
rtl/led_counter_top.sv
dv/led_counter_assert.sv
dv/led_counter_tb.sv
